// ==== src/pw_cfg_pkg.sv ====
package pw_cfg_pkg;

   //////////////////////////////////////////////////
   // configuration field widths
   //////////////////////////////////////////////////

   typedef logic [19:0] trig_delay_t;  // delay in fe_clk cycles
   typedef logic [16:0] trig_width_t;  // pulse high time in cycles
   typedef logic [3:0]  pulse_cnt_t;   // pulses per train
   typedef logic [23:0] cap_len_t;     // records per capture

   //////////////////////////////////////////////////
   // front end data
   //////////////////////////////////////////////////

   typedef logic [7:0]  byte_t;
   typedef logic [6:0]  pat_len_t;     // active pattern length in bytes

   // default pattern storage depth
   localparam int PATTERN_BYTES_MAX = 8;

endpackage

// ==== src/pw_event_pkg.sv ====
package pw_event_pkg;

   //////////////////////////////////////////////////
   // event record format
   //////////////////////////////////////////////////

   typedef logic [15:0] timestamp_t;   // cycles since capture start, wraps
   typedef logic [1:0]  evt_cmd_t;

   localparam evt_cmd_t EVT_DATA = 2'd0;  // payload is the received byte
   localparam evt_cmd_t EVT_STAT = 2'd1;  // payload bit 0 rx_active, bit 1 rx_error

   //////////////////////////////////////////////////
   // capture sequencing
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_ARMED,     // waiting for the pattern
      CAP_CAPTURE,   // recording events
      CAP_DONE       // limit reached, hold until re-armed
   } cap_state_t;

endpackage

// ==== src/phy_rx_if.sv ====
`timescale 1ns/1ps

interface phy_rx_if;
   import pw_cfg_pkg::*;

   byte_t rx_data;    // received byte
   logic  rx_valid;   // new byte on rx_data this cycle
   logic  rx_active;  // packet in progress
   logic  rx_error;

   // passive observers of the receive stream
   modport sink (
      input rx_data,
      input rx_valid,
      input rx_active,
      input rx_error
   );

endinterface

// ==== src/pw_pattern_matcher.sv ====
`timescale 1ns/1ps

module pw_pattern_matcher #(
   parameter int PATTERN_BYTES = pw_cfg_pkg::PATTERN_BYTES_MAX
) (
   input  logic                       fe_clk,
   input  logic                       rst_n_i,
   phy_rx_if.sink                     rx,
   input  logic [PATTERN_BYTES*8-1:0] pattern_i,      // byte 0 is the last one received
   input  logic [PATTERN_BYTES*8-1:0] mask_i,
   input  pw_cfg_pkg::pat_len_t       pattern_len_i,
   input  logic                       match_enable_i,
   output logic                       match_o
);
   import pw_cfg_pkg::*;

   localparam int       HIST_W  = PATTERN_BYTES * 8;
   localparam pat_len_t CNT_MAX = pat_len_t'(PATTERN_BYTES);

   logic [HIST_W-1:0] hist_q;     // byte 0 newest
   logic [HIST_W-1:0] hist_next;
   pat_len_t          byte_cnt_q;
   pat_len_t          byte_cnt_next;
   logic              sample;
   logic              hit;

   assign sample        = rx.rx_valid && rx.rx_active;  // bytes outside a packet never count
   assign hist_next     = HIST_W'({hist_q, rx.rx_data});
   assign byte_cnt_next = (byte_cnt_q == CNT_MAX) ? byte_cnt_q : byte_cnt_q + pat_len_t'(1);

   //////////////////////////////////////////////////
   // masked compare against the history incl. the incoming byte
   //////////////////////////////////////////////////
   always_comb begin
      hit = (pattern_len_i != '0) && (byte_cnt_next >= pattern_len_i);
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         if ((i < int'(pattern_len_i)) &&
             (((hist_next[i*8 +: 8] ^ pattern_i[i*8 +: 8]) & mask_i[i*8 +: 8]) != 8'h00)) begin
            hit = 1'b0;
         end
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         byte_cnt_q <= '0;
         match_o    <= 1'b0;
      end else begin
         match_o <= match_enable_i && sample && hit;
         if (!rx.rx_active) begin
            byte_cnt_q <= '0;              // packet over, start afresh
         end else if (rx.rx_valid) begin
            byte_cnt_q <= byte_cnt_next;
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (sample) begin
         hist_q <= hist_next;
      end
   end

endmodule

// ==== src/pw_trigger_timer.sv ====
`timescale 1ns/1ps

module pw_trigger_timer (
   input  logic                    fe_clk,
   input  logic                    rst_n_i,
   input  logic                    fire_i,
   input  pw_cfg_pkg::trig_delay_t trig_delay_i,
   input  pw_cfg_pkg::trig_width_t trig_width_i,
   input  pw_cfg_pkg::pulse_cnt_t  num_pulses_i,
   output logic                    trig_o
);
   import pw_cfg_pkg::*;

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_DELAY,   // low time before each pulse
      PH_HIGH
   } phase_t;

   phase_t      phase_q;
   trig_delay_t cnt_q;          // shared delay / width down-counter
   pulse_cnt_t  pulses_left_q;  // includes the pulse in progress
   trig_delay_t delay_load;
   trig_delay_t width_load;

   // counters end at zero, so load one less than the length
   assign delay_load = trig_delay_i - trig_delay_t'(1);
   assign width_load = trig_delay_t'(trig_width_i) - trig_delay_t'(1);

   //////////////////////////////////////////////////
   // pulse train sequencing
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q       <= PH_IDLE;
         cnt_q         <= '0;
         pulses_left_q <= '0;
      end else begin
         case (phase_q)
            PH_IDLE: begin
               if (fire_i) begin                 // fires only count when idle
                  phase_q       <= PH_DELAY;
                  cnt_q         <= delay_load;
                  pulses_left_q <= num_pulses_i;
               end
            end
            PH_DELAY: begin
               if (cnt_q == '0) begin
                  phase_q <= PH_HIGH;
                  cnt_q   <= width_load;
               end else begin
                  cnt_q <= cnt_q - trig_delay_t'(1);
               end
            end
            PH_HIGH: begin
               if (cnt_q != '0) begin
                  cnt_q <= cnt_q - trig_delay_t'(1);
               end else if (pulses_left_q <= pulse_cnt_t'(1)) begin
                  phase_q <= PH_IDLE;            // last pulse done
               end else begin
                  phase_q       <= PH_DELAY;
                  cnt_q         <= delay_load;
                  pulses_left_q <= pulses_left_q - pulse_cnt_t'(1);
               end
            end
            default: phase_q <= PH_IDLE;
         endcase
      end
   end

   assign trig_o = (phase_q == PH_HIGH);

endmodule

// ==== src/pw_capture_fsm.sv ====
`timescale 1ns/1ps

module pw_capture_fsm (
   input  logic                 fe_clk,
   input  logic                 rst_n_i,
   input  logic                 arm_i,
   input  logic                 trig_enable_i,
   input  pw_cfg_pkg::cap_len_t cap_len_i,
   input  logic                 match_i,
   input  logic                 evt_stb_i,
   output logic                 match_enable_o,
   output logic                 fire_o,
   output logic                 capture_en_o,
   output logic                 armed_o,
   output logic                 capture_done_o
);
   import pw_cfg_pkg::*;
   import pw_event_pkg::*;

   cap_state_t state_q;
   cap_state_t state_next;
   cap_len_t   evt_cnt_q;     // records seen this capture
   cap_len_t   evt_cnt_next;

   always_comb begin
      state_next   = state_q;
      evt_cnt_next = evt_cnt_q;
      if (arm_i) begin
         state_next   = CAP_ARMED;   // re-arm from anywhere
         evt_cnt_next = '0;
      end else begin
         case (state_q)
            CAP_ARMED: begin
               if (match_i) state_next = CAP_CAPTURE;
            end
            CAP_CAPTURE: begin
               if (evt_stb_i) begin
                  evt_cnt_next = evt_cnt_q + cap_len_t'(1);
                  if (evt_cnt_next >= cap_len_i) state_next = CAP_DONE;
               end
            end
            default: ;                       // idle and done wait for arm
         endcase
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= CAP_IDLE;
         evt_cnt_q <= '0;
      end else begin
         state_q   <= state_next;
         evt_cnt_q <= evt_cnt_next;
      end
   end

   //////////////////////////////////////////////////
   // status levels
   //////////////////////////////////////////////////
   assign match_enable_o = (state_q == CAP_ARMED);
   assign capture_en_o   = (state_q == CAP_CAPTURE);
   assign armed_o        = (state_q == CAP_ARMED) || (state_q == CAP_CAPTURE);
   assign capture_done_o = (state_q == CAP_DONE);

   // trigger starts together with the capture
   assign fire_o = match_i && trig_enable_i && !arm_i && (state_q == CAP_ARMED);

endmodule

// ==== src/pw_event_stamper.sv ====
`timescale 1ns/1ps

module pw_event_stamper (
   input  logic                     fe_clk,
   input  logic                     rst_n_i,
   phy_rx_if.sink                   rx,
   input  logic                     capture_en_i,
   output logic                     evt_valid_o,
   output pw_event_pkg::evt_cmd_t   evt_cmd_o,
   output pw_cfg_pkg::byte_t        evt_data_o,
   output pw_event_pkg::timestamp_t evt_time_o
);
   import pw_cfg_pkg::*;
   import pw_event_pkg::*;

   timestamp_t ts_q;          // 0 in the first capture cycle
   logic       active_q;
   logic       error_q;
   logic       stat_change;
   logic       evt_q;

   assign stat_change = (rx.rx_active != active_q) || (rx.rx_error != error_q);

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ts_q     <= '0;
         active_q <= 1'b0;
         error_q  <= 1'b0;
         evt_q    <= 1'b0;
      end else begin
         active_q <= rx.rx_active;   // tracked outside capture as well
         error_q  <= rx.rx_error;
         ts_q     <= capture_en_i ? ts_q + timestamp_t'(1) : '0;
         evt_q    <= capture_en_i && (rx.rx_valid || stat_change);
      end
   end

   //////////////////////////////////////////////////
   // record payload, data wins over status
   //////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rx.rx_valid) begin
         evt_cmd_o  <= EVT_DATA;
         evt_data_o <= rx.rx_data;
      end else if (stat_change) begin
         evt_cmd_o  <= EVT_STAT;
         evt_data_o <= byte_t'({rx.rx_error, rx.rx_active});
      end
      evt_time_o <= ts_q;           // stamp of the cause cycle
   end

   // a record caused in the last capture cycle is past the limit
   assign evt_valid_o = evt_q && capture_en_i;

endmodule

// ==== src/pw_sniffer_top.sv ====
`timescale 1ns/1ps

module pw_sniffer_top #(
   parameter int PATTERN_BYTES = pw_cfg_pkg::PATTERN_BYTES_MAX
) (
   input  logic                       fe_clk,
   input  logic                       rst_n_i,
   // front end receive side
   input  pw_cfg_pkg::byte_t          fe_data_i,
   input  logic                       fe_rxvalid_i,
   input  logic                       fe_rxactive_i,
   input  logic                       fe_rxerror_i,
   // control and configuration
   input  logic                       arm_i,          // one-cycle pulse
   input  logic                       trig_enable_i,
   input  logic [PATTERN_BYTES*8-1:0] pattern_i,
   input  logic [PATTERN_BYTES*8-1:0] mask_i,
   input  pw_cfg_pkg::pat_len_t       pattern_len_i,
   input  pw_cfg_pkg::trig_delay_t    trig_delay_i,
   input  pw_cfg_pkg::trig_width_t    trig_width_i,
   input  pw_cfg_pkg::pulse_cnt_t     num_pulses_i,
   input  pw_cfg_pkg::cap_len_t       cap_len_i,
   // trigger, status and event stream
   output logic                       trig_o,
   output logic                       armed_o,
   output logic                       capturing_o,
   output logic                       capture_done_o,
   output logic                       evt_valid_o,
   output pw_event_pkg::evt_cmd_t     evt_cmd_o,
   output pw_cfg_pkg::byte_t          evt_data_o,
   output pw_event_pkg::timestamp_t   evt_time_o
);

   logic match;
   logic match_enable;
   logic fire;

   phy_rx_if rx_bus ();

   assign rx_bus.rx_data   = fe_data_i;
   assign rx_bus.rx_valid  = fe_rxvalid_i;
   assign rx_bus.rx_active = fe_rxactive_i;
   assign rx_bus.rx_error  = fe_rxerror_i;

   //////////////////////////////////////////////////
   // match and trigger path
   //////////////////////////////////////////////////
   pw_pattern_matcher #(
      .PATTERN_BYTES  (PATTERN_BYTES)
   ) i_matcher (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .rx             (rx_bus.sink),
      .pattern_i      (pattern_i),
      .mask_i         (mask_i),
      .pattern_len_i  (pattern_len_i),
      .match_enable_i (match_enable),
      .match_o        (match)
   );

   pw_trigger_timer i_timer (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .fire_i         (fire),
      .trig_delay_i   (trig_delay_i),
      .trig_width_i   (trig_width_i),
      .num_pulses_i   (num_pulses_i),
      .trig_o         (trig_o)
   );

   //////////////////////////////////////////////////
   // capture control and event records
   //////////////////////////////////////////////////
   pw_capture_fsm i_fsm (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .arm_i          (arm_i),
      .trig_enable_i  (trig_enable_i),
      .cap_len_i      (cap_len_i),
      .match_i        (match),
      .evt_stb_i      (evt_valid_o),     // every record counts toward the limit
      .match_enable_o (match_enable),
      .fire_o         (fire),
      .capture_en_o   (capturing_o),
      .armed_o        (armed_o),
      .capture_done_o (capture_done_o)
   );

   pw_event_stamper i_stamper (
      .fe_clk         (fe_clk),
      .rst_n_i        (rst_n_i),
      .rx             (rx_bus.sink),
      .capture_en_i   (capturing_o),
      .evt_valid_o    (evt_valid_o),
      .evt_cmd_o      (evt_cmd_o),
      .evt_data_o     (evt_data_o),
      .evt_time_o     (evt_time_o)
   );

endmodule

// ==== tests/tb_pw_checks.svh ====
//////////////////////////////////////////////////
// expected DUT behavior updated once per cycle
//////////////////////////////////////////////////

cap_state_t m_state    = CAP_IDLE;  // state expected in this cycle
logic       m_match    = 1'b0;      // match pulse expected this cycle
int         cap_start  = 0;         // first capture cycle with timestamp 0
int         rec_cnt    = 0;
int         trig_start = 0;
int         trig_end   = 0;         // first cycle after the last pulse

// cause seen in the current cycle with its record due one cycle later
logic       nxt_rec   = 1'b0;
logic       nxt_match = 1'b0;
evt_cmd_t   nxt_cmd   = EVT_DATA;
byte_t      nxt_data  = 8'h00;
timestamp_t nxt_time  = '0;

logic       exp_valid = 1'b0;
evt_cmd_t   exp_cmd   = EVT_DATA;
byte_t      exp_data  = 8'h00;
timestamp_t exp_time  = '0;
logic       exp_trig  = 1'b0;

task automatic value_error(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
   err_cnt++;
   $display("ERROR %s got 0x%0h expected 0x%0h (cycle %0d)", name, got, exp, cyc);
endtask

// one clock cycle of PHY input while the model steps along
task automatic next_cycle(input byte_t data, input logic valid, input logic active,
                          input logic arm, input logic completes);
   cap_state_t st;
   int         period;
   @(posedge clk);
   #1;
   st     = m_state;
   period = int'(trig_width_i) + int'(trig_delay_i);
   if (arm_i) begin                          // arm wins from any state
      st      = CAP_ARMED;
      rec_cnt = 0;
   end else if (m_state == CAP_ARMED && m_match) begin
      st        = CAP_CAPTURE;
      cap_start = cyc;
      // fire went out in the match cycle and is ignored while a train runs
      if (trig_enable_i && (cyc - 1 >= trig_end)) begin
         trig_start = cyc + int'(trig_delay_i);
         trig_end   = trig_start + int'(num_pulses_i) * period - int'(trig_delay_i);
      end
   end else if (m_state == CAP_CAPTURE && exp_valid) begin
      rec_cnt++;
      if (rec_cnt >= int'(cap_len_i)) st = CAP_DONE;
   end
   exp_valid = nxt_rec && (m_state == CAP_CAPTURE) && (st == CAP_CAPTURE);
   exp_cmd   = nxt_cmd;
   exp_data  = nxt_data;
   exp_time  = nxt_time;
   exp_trig  = (cyc >= trig_start) && (cyc < trig_end) &&
               ((cyc - trig_start) % period < int'(trig_width_i));
   m_match   = nxt_match;
   m_state   = st;

   nxt_rec   = valid || (active != fe_rxactive_i);   // data wins over status
   nxt_cmd   = valid ? EVT_DATA : EVT_STAT;
   nxt_data  = valid ? data : {7'd0, active};
   nxt_time  = timestamp_t'(cyc - cap_start);
   nxt_match = completes && valid && (st == CAP_ARMED);

   fe_data_i     = data;
   fe_rxvalid_i  = valid;
   fe_rxactive_i = active;
   arm_i         = arm;
endtask

task automatic idle_cycles(input int n);
   repeat (n) next_cycle(8'h00, 1'b0, fe_rxactive_i, 1'b0, 1'b0);
endtask

task automatic send_byte(input byte_t b, input logic completes);
   next_cycle(b, 1'b1, 1'b1, 1'b0, completes);
endtask

task automatic open_packet();
   next_cycle(8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
endtask

task automatic close_packet();
   next_cycle(8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

task automatic arm_pulse();
   next_cycle(8'h00, 1'b0, fe_rxactive_i, 1'b1, 1'b0);
endtask

//////////////////////////////////////////////////
// checks sampled on the falling edge between input changes
//////////////////////////////////////////////////
a_trig: assert property (@(negedge clk) disable iff (!rst_n) trig_o == exp_trig)
   else value_error("trig_o", 32'(trig_o), 32'(exp_trig));
a_armed: assert property (@(negedge clk) disable iff (!rst_n)
   armed_o == (m_state == CAP_ARMED || m_state == CAP_CAPTURE))
   else value_error("armed_o", 32'(armed_o),
                    32'(m_state == CAP_ARMED || m_state == CAP_CAPTURE));
a_capturing: assert property (@(negedge clk) disable iff (!rst_n)
   capturing_o == (m_state == CAP_CAPTURE))
   else value_error("capturing_o", 32'(capturing_o), 32'(m_state == CAP_CAPTURE));
a_done: assert property (@(negedge clk) disable iff (!rst_n)
   capture_done_o == (m_state == CAP_DONE))
   else value_error("capture_done_o", 32'(capture_done_o), 32'(m_state == CAP_DONE));
a_evt_valid: assert property (@(negedge clk) disable iff (!rst_n) evt_valid_o == exp_valid)
   else value_error("evt_valid_o", 32'(evt_valid_o), 32'(exp_valid));
a_evt_cmd: assert property (@(negedge clk) disable iff (!rst_n)
   exp_valid |-> evt_cmd_o == exp_cmd)
   else value_error("evt_cmd_o", 32'(evt_cmd_o), 32'(exp_cmd));
a_evt_data: assert property (@(negedge clk) disable iff (!rst_n)
   exp_valid |-> evt_data_o == exp_data)
   else value_error("evt_data_o", 32'(evt_data_o), 32'(exp_data));
a_evt_time: assert property (@(negedge clk) disable iff (!rst_n)
   exp_valid |-> evt_time_o == exp_time)
   else value_error("evt_time_o", 32'(evt_time_o), 32'(exp_time));

// ==== tests/tb_pw_sniffer.sv ====
`timescale 1ns/1ps

module tb_pw_sniffer;
   import pw_cfg_pkg::*;
   import pw_event_pkg::*;

   localparam int PAT_BYTES      = PATTERN_BYTES_MAX;
   localparam int TIMEOUT_CYCLES = 3000;   // about twice the run, trigger train dominates

   logic                   clk;
   logic                   rst_n;
   byte_t                  fe_data_i;
   logic                   fe_rxvalid_i;
   logic                   fe_rxactive_i;
   logic                   fe_rxerror_i;
   logic                   arm_i;
   logic                   trig_enable_i;
   logic [PAT_BYTES*8-1:0] pattern_i;
   logic [PAT_BYTES*8-1:0] mask_i;
   pat_len_t               pattern_len_i;
   trig_delay_t            trig_delay_i;
   trig_width_t            trig_width_i;
   pulse_cnt_t             num_pulses_i;
   cap_len_t               cap_len_i;
   logic                   trig_o;
   logic                   armed_o;
   logic                   capturing_o;
   logic                   capture_done_o;
   logic                   evt_valid_o;
   evt_cmd_t               evt_cmd_o;
   byte_t                  evt_data_o;
   timestamp_t             evt_time_o;

   int cyc      = 0;   // rising edges so far
   int err_cnt  = 0;
   int err_mark = 0;
   int test_num = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;

   pw_sniffer_top #(
      .PATTERN_BYTES (PAT_BYTES)
   ) i_dut (
      .fe_clk         (clk),
      .rst_n_i        (rst_n),
      .fe_data_i      (fe_data_i),
      .fe_rxvalid_i   (fe_rxvalid_i),
      .fe_rxactive_i  (fe_rxactive_i),
      .fe_rxerror_i   (fe_rxerror_i),
      .arm_i          (arm_i),
      .trig_enable_i  (trig_enable_i),
      .pattern_i      (pattern_i),
      .mask_i         (mask_i),
      .pattern_len_i  (pattern_len_i),
      .trig_delay_i   (trig_delay_i),
      .trig_width_i   (trig_width_i),
      .num_pulses_i   (num_pulses_i),
      .cap_len_i      (cap_len_i),
      .trig_o         (trig_o),
      .armed_o        (armed_o),
      .capturing_o    (capturing_o),
      .capture_done_o (capture_done_o),
      .evt_valid_o    (evt_valid_o),
      .evt_cmd_o      (evt_cmd_o),
      .evt_data_o     (evt_data_o),
      .evt_time_o     (evt_time_o)
   );

   `include "tb_pw_checks.svh"

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $finish;
      end
   end

   // bit 7 clear, so filler never hits a masked pattern byte
   function automatic byte_t filler_byte();
      logic [31:0] r;
      r = $urandom;
      return {1'b0, r[6:0]};
   endfunction

   task automatic finish_test(input string name);
      test_num++;
      if (err_cnt == err_mark) begin
         pass_cnt++;
         $display("test %0d %s: pass", test_num, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: FAIL with %0d errors", test_num, name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   initial begin
      void'($urandom(22));
      rst_n         = 1'b0;
      fe_data_i     = 8'h00;
      fe_rxvalid_i  = 1'b0;
      fe_rxactive_i = 1'b0;
      fe_rxerror_i  = 1'b0;
      arm_i         = 1'b0;
      trig_enable_i = 1'b1;
      pattern_i     = 64'h0000_0000_00A5_00C3;  // A5, any byte, C3
      mask_i        = 64'h0000_0000_00FF_00FF;
      pattern_len_i = 7'd3;
      trig_delay_i  = 20'd200;
      trig_width_i  = 17'd60;
      num_pulses_i  = 4'd5;
      cap_len_i     = 24'd10;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      open_packet();                  // pattern on the line, never armed
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hA5, 1'b0);
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hC3, 1'b1);
      close_packet();
      idle_cycles(4);
      finish_test("quiet before arm");

      // trigger disabled for this capture
      trig_enable_i = 1'b0;
      arm_pulse();
      idle_cycles(2);
      open_packet();                  // masked byte differs
      send_byte(8'hA5, 1'b0);
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hC4, 1'b0);
      close_packet();
      idle_cycles(2);
      open_packet();                  // pattern split over two packets
      send_byte(8'hA5, 1'b0);
      send_byte(filler_byte(), 1'b0);
      close_packet();
      open_packet();
      send_byte(8'hC3, 1'b0);
      close_packet();
      idle_cycles(2);
      open_packet();
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hA5, 1'b0);
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hC3, 1'b1);
      send_byte(filler_byte(), 1'b0);
      send_byte(filler_byte(), 1'b0);
      close_packet();
      idle_cycles(3);
      finish_test("masked pattern match");

      trig_enable_i = 1'b1;
      arm_pulse();                    // re-arm out of the running capture
      idle_cycles(2);
      open_packet();
      send_byte(8'hA5, 1'b0);
      send_byte(filler_byte(), 1'b0);
      send_byte(8'hC3, 1'b1);
      close_packet();
      idle_cycles(int'(trig_delay_i) +
                  int'(num_pulses_i) * (int'(trig_width_i) + int'(trig_delay_i)) + 4);
      finish_test("trigger pulse train");

      open_packet();
      for (int i = 0; i < 4; i++) begin
         send_byte(byte_t'($urandom), 1'b0);
         idle_cycles(i);              // growing gaps between bytes
      end
      close_packet();
      idle_cycles(2);
      finish_test("event records");

      open_packet();
      repeat (4) send_byte(byte_t'($urandom), 1'b0);  // last one is past the limit
      close_packet();
      idle_cycles(3);
      arm_pulse();
      idle_cycles(3);
      finish_test("capture length and re-arm");

      $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== pw_sniffer.f ====
+incdir+tests
src/pw_cfg_pkg.sv
src/pw_event_pkg.sv
src/phy_rx_if.sv
src/pw_pattern_matcher.sv
src/pw_trigger_timer.sv
src/pw_capture_fsm.sv
src/pw_event_stamper.sv
src/pw_sniffer_top.sv
tests/tb_pw_sniffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the sniffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_pw_sniffer -f pw_sniffer.f -o tb_pw_sniffer
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_pw_sniffer)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

# the run only counts as passed when the testbench says so
if echo "$sim_out" | grep -qx "Everything OK"; then
   exit 0
fi
echo "simulation did not report a pass"
exit 1
